// File: Makefile
# Verilator build and run of the merge pipe testbench

VERILATOR ?= verilator
TOP       := flow_merge_pipe_tb
FILELIST  := flow_merge_pipe.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

# Rebuild when any listed source, the shared header or the file list changes
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep '^>>> PASS$$' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: bench/flow_merge_pipe_properties.sv
// --------------------
// Protocol checks on the merge pipe ports, attached with bind
// The push stability checks apply to whatever drives the push channels
// --------------------

`timescale 1ns/1ns

`include "flow_defines.svh"

module flow_merge_pipe_properties (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    push0_valid,
  input logic                    push1_valid,
  input logic                    push0_ready,
  input logic                    push1_ready,
  input flow_op_pkg::op_e        push0_op,
  input flow_op_pkg::op_e        push1_op,
  input logic [`FLOW_DATA_W-1:0] push0_operand,
  input logic [`FLOW_DATA_W-1:0] push1_operand,
  input logic                    pop_ready,
  input logic                    pop_valid,
  input flow_chan_pkg::src_e     pop_src,
  input logic [`FLOW_DATA_W-1:0] pop_data
);

  // A result that waits on pop_ready keeps its source and data
  pop_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_src) && $stable(pop_data))
    else $error("pop channel changed while stalled");

  // Both stages come out of reset empty
  pop_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !pop_valid)
    else $error("pop_valid high right after reset");

  // The arbiter grants a single channel per cycle
  one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    push0_valid && push1_valid |-> !(push0_ready && push1_ready))
    else $error("both push channels ready while both are valid");

  // A stalled push request stays on the port until it is taken
  push0_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    push0_valid && !push0_ready |=> push0_valid && $stable(push0_op) && $stable(push0_operand))
    else $error("push channel 0 changed while stalled");

  push1_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    push1_valid && !push1_ready |=> push1_valid && $stable(push1_op) && $stable(push1_operand))
    else $error("push channel 1 changed while stalled");

endmodule : flow_merge_pipe_properties

bind flow_merge_pipe flow_merge_pipe_properties u_props (
  .clk(clk), .rst_n(rst_n),
  .push0_valid(push0_valid), .push1_valid(push1_valid),
  .push0_ready(push0_ready), .push1_ready(push1_ready),
  .push0_op(push0_op), .push1_op(push1_op),
  .push0_operand(push0_operand), .push1_operand(push1_operand),
  .pop_ready(pop_ready), .pop_valid(pop_valid), .pop_src(pop_src), .pop_data(pop_data)
);

// File: bench/flow_merge_pipe_tb.sv
// --------------------
// Directed testbench for the two-channel merge pipe
// Pop results are compared with a model of the per-source accumulators
// The run stops at the first mismatch
// --------------------

`timescale 1ns/1ns

`include "flow_defines.svh"

module flow_merge_pipe_tb;

  localparam int clk_period   = 10;
  localparam int reset_cycles = 4;
  // Items pushed over all tests, which sizes the watchdog
  localparam int total_items    = 101;
  localparam int timeout_cycles = (total_items + reset_cycles) * 20;

  logic clk, rst_n;
  logic push0_valid, push1_valid, push0_ready, push1_ready;
  flow_op_pkg::op_e push0_op, push1_op;
  logic [`FLOW_DATA_W-1:0] push0_operand, push1_operand, pop_data;
  logic pop_ready, pop_valid;
  flow_chan_pkg::src_e pop_src;

  // Requests waiting per channel and expected results per source
  flow_op_pkg::req_t       pend_q [2][$];
  logic [`FLOW_DATA_W-1:0] exp_q [2][$];
  logic [`FLOW_DATA_W-1:0] model_acc [2];
  // Every pop as {src, data} in the order it left the DUT
  logic [`FLOW_DATA_W:0]   pop_log [$];
  logic        acc0, acc1, rand_mode;
  logic [31:0] rng;
  int          pushed, popped;
  string       cur_test;

  flow_merge_pipe dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift32(rng);
    r = rng;
  endtask

  function automatic flow_op_pkg::req_t make_req(input flow_op_pkg::op_e op,
                                                 input logic [`FLOW_DATA_W-1:0] operand);
    flow_op_pkg::req_t r;
    r.op      = op;
    r.operand = operand;
    return r;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
      report_error($sformatf("Error in %s: %s expected %0h, actual %0h", cur_test, what, exp, act));
  endtask

  // Applies the opcode rules to the model and queues the result for its source
  task automatic apply_model(input int s, input flow_op_pkg::req_t r);
    logic [`FLOW_DATA_W-1:0] acc;
    logic [`FLOW_DATA_W-1:0] res;
    acc = model_acc[s];
    res = r.operand;
    case (r.op)
      flow_op_pkg::op_add: begin
        acc = acc + r.operand;
        res = acc;
      end
      flow_op_pkg::op_xor: begin
        acc = acc ^ r.operand;
        res = acc;
      end
      flow_op_pkg::op_clr: begin
        acc = '0;
        res = '0;
      end
      default: res = r.operand;
    endcase
    model_acc[s] = acc;
    exp_q[s].push_back(res);
  endtask

  // Presents the head of a channel's queue and holds it until it is taken
  task automatic feed(input int c, input logic accepted, inout logic valid,
                      inout flow_op_pkg::op_e op, inout logic [`FLOW_DATA_W-1:0] operand);
    logic [31:0] r;
    if (accepted) void'(pend_q[c].pop_front());
    if (!valid || accepted) begin
      next_rand(r);
      if (pend_q[c].size() != 0 && (!rand_mode || r[0])) begin
        valid   = 1'b1;
        op      = pend_q[c][0].op;
        operand = pend_q[c][0].operand;
      end else begin
        valid = 1'b0;
      end
    end
  endtask

  // Returns once every queued request has been pushed and popped
  task automatic wait_idle();
    do @(posedge clk);
    while (pend_q[0].size() != 0 || pend_q[1].size() != 0 || push0_valid || push1_valid ||
           exp_q[0].size() != 0 || exp_q[1].size() != 0);
  endtask

  // --------------------
  // Drivers and monitor
  // --------------------

  // Inputs change 1 ns after the rising edge
  initial begin : feeder
    logic [31:0] r;
    forever begin
      @(posedge clk);
      #1;
      feed(0, acc0, push0_valid, push0_op, push0_operand);
      feed(1, acc1, push1_valid, push1_op, push1_operand);
      next_rand(r);
      pop_ready = !rand_mode || r[0];
    end
  end

  // Sampled at the falling edge where the handshakes of the next edge are settled
  always @(negedge clk) begin : monitor
    logic [`FLOW_DATA_W-1:0] want;
    if (rst_n) begin
      acc0 = push0_valid && push0_ready;
      acc1 = push1_valid && push1_ready;
      if (acc0) begin
        apply_model(0, make_req(push0_op, push0_operand));
        pushed++;
      end
      if (acc1) begin
        apply_model(1, make_req(push1_op, push1_operand));
        pushed++;
      end
      if (pop_valid && pop_ready) begin
        popped++;
        assert (exp_q[pop_src].size() != 0) else
          report_error("A pop transfer arrived with no result pending for its source");
        want = exp_q[pop_src].pop_front();
        check_eq($sformatf("pop data of source %0d", pop_src), 32'(want), 32'(pop_data));
        pop_log.push_back({pop_src, pop_data});
      end
    end
  end

  // --------------------
  // Tests
  // --------------------

  task automatic test_reset();
    cur_test = "reset";
    @(negedge clk);
    check_eq("pop_valid", 0, 32'(pop_valid));
    check_eq("push0_ready", 1, 32'(push0_ready));
    check_eq("push1_ready", 1, 32'(push1_ready));
  endtask

  task automatic test_latency();
    cur_test = "latency";
    @(posedge clk);
    pend_q[0].push_back(make_req(flow_op_pkg::op_pass, 16'h1234));
    do @(negedge clk);
    while (!(push0_valid && push0_ready));
    // Accepted into stage 1 on the next edge, so the pop side is still empty
    @(negedge clk);
    check_eq("pop_valid after accept edge", 0, 32'(pop_valid));
    @(negedge clk);
    check_eq("pop_valid one edge later", 1, 32'(pop_valid));
    check_eq("pop_src", 0, 32'(pop_src));
    check_eq("pop_data", 32'h1234, 32'(pop_data));
    wait_idle();
  endtask

  task automatic test_opcodes();
    logic [`FLOW_DATA_W-1:0] want [8];
    want = '{16'h0000, 16'h0010, 16'h0008, 16'h00f7, 16'h5555, 16'h00f8, 16'h0000, 16'h0003};
    cur_test = "opcodes";
    @(posedge clk);
    pop_log.delete();
    pend_q[0].push_back(make_req(flow_op_pkg::op_clr, 16'hbeef));
    pend_q[0].push_back(make_req(flow_op_pkg::op_add, 16'h0010));
    // 0x0010 + 0xfff8 wraps to 0x0008
    pend_q[0].push_back(make_req(flow_op_pkg::op_add, 16'hfff8));
    pend_q[0].push_back(make_req(flow_op_pkg::op_xor, 16'h00ff));
    pend_q[0].push_back(make_req(flow_op_pkg::op_pass, 16'h5555));
    pend_q[0].push_back(make_req(flow_op_pkg::op_add, 16'h0001));
    pend_q[0].push_back(make_req(flow_op_pkg::op_clr, 16'h0000));
    wait_idle();
    // Source 1 still holds zero, so the sum is just the operand
    pend_q[1].push_back(make_req(flow_op_pkg::op_add, 16'h0003));
    wait_idle();
    check_eq("result count", 8, pop_log.size());
    for (int i = 0; i < 8; i++) begin
      check_eq($sformatf("result %0d", i), 32'(want[i]), 32'(pop_log[i][`FLOW_DATA_W-1:0]));
      check_eq($sformatf("source %0d", i), (i < 7) ? 0 : 1, 32'(pop_log[i][`FLOW_DATA_W]));
    end
  endtask

  task automatic test_round_robin();
    cur_test = "round robin";
    @(posedge clk);
    pop_log.delete();
    for (int i = 0; i < 6; i++) begin
      pend_q[0].push_back(make_req(flow_op_pkg::op_pass, 16'(16'h0100 + i)));
      pend_q[1].push_back(make_req(flow_op_pkg::op_pass, 16'(16'h0200 + i)));
    end
    wait_idle();
    check_eq("transfer count", 12, pop_log.size());
    // The opcode test ended on source 1, so source 0 wins first and the order alternates
    for (int i = 0; i < 12; i++) begin
      check_eq($sformatf("source of transfer %0d", i), i % 2, 32'(pop_log[i][`FLOW_DATA_W]));
    end
  endtask

  task automatic test_back_pressure();
    logic [31:0] r;
    cur_test = "back-pressure";
    @(posedge clk);
    rand_mode = 1'b1;
    for (int i = 0; i < 40; i++) begin
      next_rand(r);
      pend_q[0].push_back(make_req(flow_op_pkg::op_e'(r[17:16]), r[15:0]));
      next_rand(r);
      pend_q[1].push_back(make_req(flow_op_pkg::op_e'(r[17:16]), r[15:0]));
    end
    wait_idle();
    rand_mode = 1'b0;
    check_eq("items pushed", total_items, pushed);
    check_eq("items popped", pushed, popped);
  endtask

  // --------------------
  // Sequence and watchdog
  // --------------------

  initial begin
    rst_n         = 1'b0;
    push0_valid   = 1'b0;
    push1_valid   = 1'b0;
    push0_op      = flow_op_pkg::op_pass;
    push1_op      = flow_op_pkg::op_pass;
    push0_operand = '0;
    push1_operand = '0;
    pop_ready     = 1'b1;
    rand_mode     = 1'b0;
    rng           = 32'd88007;
    acc0          = 1'b0;
    acc1          = 1'b0;
    pushed        = 0;
    popped        = 0;
    model_acc[0]  = '0;
    model_acc[1]  = '0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
    test_reset();
    test_latency();
    test_opcodes();
    test_round_robin();
    test_back_pressure();
    if (pushed == popped && exp_q[0].size() == 0 && exp_q[1].size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      report_error("Results were still pending when the tests ended");
    end
  end

  initial begin
    #(timeout_cycles * clk_period);
    report_error("Watchdog expired before the tests finished");
  end

endmodule : flow_merge_pipe_tb

// File: flow_merge_pipe.f
+incdir+src
src/flow_chan_pkg.sv
src/flow_op_pkg.sv
src/flow_if.sv
src/flow_reg_fwd.sv
src/flow_arb_ctrl.sv
src/flow_op_unit.sv
src/flow_merge_pipe.sv
bench/flow_merge_pipe_properties.sv
bench/flow_merge_pipe_tb.sv

// File: src/flow_arb_ctrl.sv
// --------------------
// Round-robin merge of two push channels into one ready/valid stream
// The grant is purely combinational and only the pointer is registered
// The grant can change while stalled if the other channel raises valid
// --------------------

`timescale 1ns/1ns

module flow_arb_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push0_valid,
  input  logic              push1_valid,
  output logic              push0_ready,
  output logic              push1_ready,
  input  flow_op_pkg::req_t push0_req,
  input  flow_op_pkg::req_t push1_req,
  flow_if.pop               arb
);

  flow_chan_pkg::arb_state_e last_q;
  flow_chan_pkg::src_e       grant;
  logic                      xfer;

  // --------------------
  // Grant selection
  // --------------------

  // A lone valid channel wins outright
  // With both valid, the channel that did not win last time goes first
  // With neither valid the grant is a don't care and channel 0 is picked
  always_comb begin
    if (push0_valid && push1_valid) begin
      if (last_q == flow_chan_pkg::last_0) begin
        grant = flow_chan_pkg::src_1;
      end else begin
        grant = flow_chan_pkg::src_0;
      end
    end else if (push1_valid) begin
      grant = flow_chan_pkg::src_1;
    end else begin
      grant = flow_chan_pkg::src_0;
    end
  end

  // A channel sees downstream ready when it holds the grant or the other channel is idle
  // With both valid only the granted channel is ready
  assign push0_ready = arb.ready && (grant == flow_chan_pkg::src_0 || !push1_valid);
  assign push1_ready = arb.ready && (grant == flow_chan_pkg::src_1 || !push0_valid);

  // --------------------
  // Merged stream
  // --------------------

  assign arb.valid   = push0_valid || push1_valid;
  assign arb.src     = grant;
  assign arb.payload = (grant == flow_chan_pkg::src_1) ? push1_req : push0_req;

  assign xfer = arb.valid && arb.ready;

  // Pointer moves only on a completed transfer
  // A stall therefore keeps the same priority order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= flow_chan_pkg::last_1;
    end else if (xfer) begin
      if (grant == flow_chan_pkg::src_1) begin
        last_q <= flow_chan_pkg::last_1;
      end else begin
        last_q <= flow_chan_pkg::last_0;
      end
    end
  end

endmodule : flow_arb_ctrl

// File: src/flow_chan_pkg.sv
// --------------------
// Channel side types of the merge pipe
// Exactly two sources exist, so a source id fits in one bit
// --------------------

package flow_chan_pkg;

  // Source id carried alongside every payload
  // It also selects the accumulator in the operate unit
  typedef enum logic {
    src_0 = 1'b0,
    src_1 = 1'b1
  } src_e;

  // Round-robin pointer that names the source which won the last transfer
  // The other source gets priority when both are valid
  typedef enum logic {
    last_0 = 1'b0,
    last_1 = 1'b1
  } arb_state_e;

endpackage : flow_chan_pkg

// File: src/flow_defines.svh
// --------------------
// Widths shared by the merge pipe and its packages
// The result width equals the operand width, so sums wrap modulo 2^16
// --------------------

`ifndef FLOW_DEFINES_SVH
`define FLOW_DEFINES_SVH

// Operand, accumulator and result width in bits
`define FLOW_DATA_W 16

// Opcode field width in bits, enough for the four operations
`define FLOW_OP_W 2

`endif

// File: src/flow_if.sv
// --------------------
// Ready/valid channel with a source id and a generic payload
// A transfer happens on a rising clk edge with valid and ready both high
// The source holds valid, src and payload while stalled
// --------------------

`timescale 1ns/1ns

interface flow_if #(
  parameter int PAYLOAD_W = 16
);

  // Qualifies src and payload, driven by the source side
  logic valid;

  // Sink can take the item this cycle
  logic ready;

  // Which push channel the item came from
  flow_chan_pkg::src_e src;

  logic [PAYLOAD_W-1:0] payload;

  // --------------------
  // Sink side of the channel, as seen by a consumer
  modport push (
    input  valid,
    input  src,
    input  payload,
    output ready
  );

  // Source side of the channel, as seen by a producer
  modport pop (
    output valid,
    output src,
    output payload,
    input  ready
  );

endinterface : flow_if

// File: src/flow_merge_pipe.sv
// --------------------
// Two-channel merge with an operate stage and plain ready/valid ports
// Push to pop latency is two edges
// Throughput is one item per cycle
// At most two items are held inside and per-source order is kept
// --------------------

`timescale 1ns/1ns

`include "flow_defines.svh"

module flow_merge_pipe (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push0_valid,
  input  logic                    push1_valid,
  output logic                    push0_ready,
  output logic                    push1_ready,
  input  flow_op_pkg::op_e        push0_op,
  input  flow_op_pkg::op_e        push1_op,
  input  logic [`FLOW_DATA_W-1:0] push0_operand,
  input  logic [`FLOW_DATA_W-1:0] push1_operand,
  input  logic                    pop_ready,
  output logic                    pop_valid,
  output flow_chan_pkg::src_e     pop_src,
  output logic [`FLOW_DATA_W-1:0] pop_data
);

  localparam int req_w = $bits(flow_op_pkg::req_t);
  localparam int res_w = $bits(flow_op_pkg::res_t);

  flow_op_pkg::req_t push0_req;
  flow_op_pkg::req_t push1_req;
  flow_op_pkg::res_t pop_res;

  // --------------------
  // Channels between the stages
  // --------------------

  // Arbiter output into the stage 1 register
  flow_if #(.PAYLOAD_W(req_w)) arb_bus ();

  // Stage 1 register output into the operate unit
  flow_if #(.PAYLOAD_W(req_w)) req_bus ();

  // Operate unit output into the stage 2 register
  flow_if #(.PAYLOAD_W(res_w)) res_bus ();

  // Stage 2 register output, broken out to the plain pop ports
  flow_if #(.PAYLOAD_W(res_w)) pop_bus ();

  // Pack each push channel into a request
  assign push0_req.op      = push0_op;
  assign push0_req.operand = push0_operand;
  assign push1_req.op      = push1_op;
  assign push1_req.operand = push1_operand;

  // --------------------
  // Stages
  // --------------------

  flow_arb_ctrl u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .push0_valid (push0_valid),
    .push1_valid (push1_valid),
    .push0_ready (push0_ready),
    .push1_ready (push1_ready),
    .push0_req   (push0_req),
    .push1_req   (push1_req),
    .arb         (arb_bus.pop)
  );

  flow_reg_fwd #(.PAYLOAD_W(req_w)) reg_req (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (arb_bus.push),
    .pop   (req_bus.pop)
  );

  flow_op_unit u_op (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req_bus.push),
    .res   (res_bus.pop)
  );

  flow_reg_fwd #(.PAYLOAD_W(res_w)) reg_res (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (res_bus.push),
    .pop   (pop_bus.pop)
  );

  // The result struct of the pop side is unpacked to plain data
  assign pop_bus.ready = pop_ready;
  assign pop_valid     = pop_bus.valid;
  assign pop_src       = pop_bus.src;
  assign pop_res       = pop_bus.payload;
  assign pop_data      = pop_res.data;

endmodule : flow_merge_pipe

// File: src/flow_op_pkg.sv
// --------------------
// Opcode and payload types of the operate stage
// Needs flow_defines.svh on the include path
// --------------------

`include "flow_defines.svh"

package flow_op_pkg;

  // Operation applied to the accumulator of the request's source
  typedef enum logic [`FLOW_OP_W-1:0] {
    op_pass,
    op_add,
    op_xor,
    op_clr
  } op_e;

  // Stage 1 payload with the opcode in the upper bits and the operand below
  typedef struct packed {
    op_e                     op;
    logic [`FLOW_DATA_W-1:0] operand;
  } req_t;

  // Stage 2 payload that carries the value returned on the pop channel
  typedef struct packed {
    logic [`FLOW_DATA_W-1:0] data;
  } res_t;

endpackage : flow_op_pkg

// File: src/flow_op_unit.sv
// --------------------
// Operate stage with one accumulator per source
// Combinational from req to res with a commit only on a res transfer
// Additions wrap at the data width
// --------------------

`timescale 1ns/1ns

`include "flow_defines.svh"

module flow_op_unit (
  input logic clk,
  input logic rst_n,
  flow_if.push req,
  flow_if.pop  res
);

  logic [`FLOW_DATA_W-1:0] acc_q [2];
  logic [`FLOW_DATA_W-1:0] acc_cur;
  logic [`FLOW_DATA_W-1:0] acc_next;
  flow_op_pkg::req_t       req_pl;
  flow_op_pkg::res_t       res_pl;

  // --------------------
  // Operation
  // --------------------

  assign req_pl  = req.payload;
  assign acc_cur = acc_q[req.src];

  // New accumulator value and the result returned for this request
  // Pass leaves the accumulator alone and echoes the operand
  always_comb begin
    acc_next    = acc_cur;
    res_pl.data = req_pl.operand;
    case (req_pl.op)
      flow_op_pkg::op_add: begin
        acc_next    = acc_cur + req_pl.operand;
        res_pl.data = acc_next;
      end
      flow_op_pkg::op_xor: begin
        acc_next    = acc_cur ^ req_pl.operand;
        res_pl.data = acc_next;
      end
      flow_op_pkg::op_clr: begin
        acc_next    = '0;
        res_pl.data = '0;
      end
      default: begin
        acc_next    = acc_cur;
        res_pl.data = req_pl.operand;
      end
    endcase
  end

  // Stage is a straight pass for the handshake
  assign res.valid   = req.valid;
  assign res.src     = req.src;
  assign res.payload = res_pl;
  assign req.ready   = res.ready;

  // --------------------
  // Accumulators
  // --------------------

  // A stalled request must not update state twice, so commit on the transfer only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q[0] <= '0;
      acc_q[1] <= '0;
    end else if (res.valid && res.ready) begin
      acc_q[res.src] <= acc_next;
    end
  end

endmodule : flow_op_unit

// File: src/flow_reg_fwd.sv
// --------------------
// One-entry forward flow register that behaves like a one-deep FIFO
// Valid and payload are cut by a register while ready stays combinational
// Full throughput needs pop ready high because there is no skid entry
// --------------------

`timescale 1ns/1ns

module flow_reg_fwd #(
  parameter int PAYLOAD_W = 16
) (
  input logic clk,
  input logic rst_n,
  flow_if.push push,
  flow_if.pop  pop
);

  logic                 valid_q;
  logic                 load;
  flow_chan_pkg::src_e  src_q;
  logic [PAYLOAD_W-1:0] payload_q;

  // --------------------
  // Handshake
  // --------------------

  // Accept when the entry is empty or leaves on this same edge
  // Zero cycles from pop ready to push ready
  assign push.ready = pop.ready || !valid_q;

  assign load = push.valid && push.ready;

  // Valid stays set while an entry is held, or refills from push
  // An empty stage has valid low, so push ready comes up right out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= push.valid || !push.ready;
    end
  end

  // --------------------
  // Datapath
  // --------------------

  // Only loads on an accepted push, so a stalled entry keeps its value
  always_ff @(posedge clk) begin
    if (load) begin
      src_q     <= push.src;
      payload_q <= push.payload;
    end
  end

  assign pop.valid   = valid_q;
  assign pop.src     = src_q;
  assign pop.payload = payload_q;

endmodule : flow_reg_fwd
